// ==== verilog/lsq_config.svh ====
// Load/store path configuration
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// Queue and buffer depths, powers of two
`define LSQ_ENTRIES 8
`define SB_ENTRIES 4

// Fully associative data TLB
`define TLB_ENTRIES 4

// Data memory in words, indexed by physical address bits 9:2
`define MEM_WORDS 256

// First physical address outside of memory
`define PHYS_MEM_LIMIT 32'h0001_0000

// Width of the global instruction index
`define GL_IDX_BITS 6

`endif

// ==== verilog/lsq_pkg.sv ====
// Load/store path types
`default_nettype none

`include "lsq_config.svh"

package lsq_pkg;

    typedef logic [31:0] vaddr_t;   // Virtual address
    typedef logic [31:0] paddr_t;   // Physical address
    typedef logic [19:0] vpn_t;     // 4 KiB pages
    typedef logic [19:0] ppn_t;
    typedef logic [31:0] word_t;

    typedef logic [`GL_IDX_BITS-1:0] gl_index_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_t;

    // Exception causes, listed in check priority
    typedef enum logic [2:0] {
        XC_NONE,
        XC_LD_MISALIGNED,
        XC_ST_MISALIGNED,
        XC_LD_PAGE_FAULT,
        XC_ST_PAGE_FAULT,
        XC_LD_ACCESS_FAULT,
        XC_ST_ACCESS_FAULT
    } xcpt_cause_t;

endpackage

`default_nettype wire

// ==== verilog/dtlb.sv ====
// Data TLB
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module dtlb
    import lsq_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic fill_i,
    input  vpn_t fill_vpn_i,
    input  ppn_t fill_ppn_i,
    input  logic fill_writable_i,
    input  vpn_t lookup_vpn_i,
    output logic lookup_hit_o,
    output ppn_t lookup_ppn_o,
    output logic lookup_writable_o
);

    localparam int IDX_W = $clog2(`TLB_ENTRIES);

    logic ent_valid [`TLB_ENTRIES];
    vpn_t ent_vpn   [`TLB_ENTRIES];
    ppn_t ent_ppn   [`TLB_ENTRIES];
    logic ent_wr    [`TLB_ENTRIES];

    logic [IDX_W-1:0] rr_ptr;     // Next victim
    logic [IDX_W-1:0] fill_idx;
    logic             fill_match;

    always_comb begin
        lookup_hit_o      = 1'b0;
        lookup_ppn_o      = '0;
        lookup_writable_o = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (ent_valid[i] && ent_vpn[i] == lookup_vpn_i) begin
                lookup_hit_o      = 1'b1;
                lookup_ppn_o      = ent_ppn[i];
                lookup_writable_o = ent_wr[i];
            end
        end
    end

    // A fill for a page already present reuses its entry
    always_comb begin
        fill_match = 1'b0;
        fill_idx   = rr_ptr;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (ent_valid[i] && ent_vpn[i] == fill_vpn_i) begin
                fill_match = 1'b1;
                fill_idx   = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rr_ptr <= '0;
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else if (fill_i) begin
            ent_valid[fill_idx] <= 1'b1;
            if (!fill_match) rr_ptr <= rr_ptr + 1'b1;   // Advance only on replacement
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            ent_vpn[fill_idx] <= fill_vpn_i;
            ent_ppn[fill_idx] <= fill_ppn_i;
            ent_wr[fill_idx]  <= fill_writable_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_store_queue.sv ====
// Load/store queue
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module load_store_queue
    import lsq_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  logic        instr_valid_i,
    input  logic        instr_is_store_i,
    input  mem_size_t   instr_size_i,
    input  vaddr_t      instr_addr_i,
    input  word_t       instr_data_i,
    input  gl_index_t   instr_gl_idx_i,
    input  logic        translate_en_i,
    input  logic        tlb_hit_i,
    input  ppn_t        tlb_ppn_i,
    input  logic        tlb_writable_i,
    input  logic        sb_full_i,
    input  logic        sb_empty_i,
    input  logic        sb_collision_i,
    input  logic        port_busy_i,
    output logic        full_o,
    output logic        empty_o,
    output logic        pmu_load_after_store_o,
    output vpn_t        tlb_vpn_o,
    output logic        sb_push_o,
    output paddr_t      head_paddr_o,
    output mem_size_t   head_size_o,
    output word_t       head_data_o,
    output gl_index_t   head_gl_idx_o,
    output logic        issue_o,
    output xcpt_cause_t issue_xcpt_o,
    output logic        issue_is_store_o
);

    localparam int PTR_W = $clog2(`LSQ_ENTRIES);
    localparam int CNT_W = PTR_W + 1;

    // Address field holds the physical address once translated
    logic        ent_is_store [`LSQ_ENTRIES];
    mem_size_t   ent_size     [`LSQ_ENTRIES];
    vaddr_t      ent_addr     [`LSQ_ENTRIES];
    word_t       ent_data     [`LSQ_ENTRIES];
    gl_index_t   ent_gl_idx   [`LSQ_ENTRIES];
    xcpt_cause_t ent_xcpt     [`LSQ_ENTRIES];

    logic [PTR_W-1:0] head;       // Oldest translated entry
    logic [PTR_W-1:0] tail;       // Next free entry
    logic [PTR_W-1:0] xlat_ptr;   // Oldest untranslated entry
    logic [CNT_W-1:0] num_to_translate;
    logic [CNT_W-1:0] num_to_exe;

    logic        accept;
    logic        xlat_ok;
    logic        head_valid;
    logic        pop;
    vaddr_t      xlat_vaddr;
    paddr_t      xlat_paddr;
    xcpt_cause_t xlat_cause;

    assign full_o  = ((num_to_translate + num_to_exe) == CNT_W'(`LSQ_ENTRIES)) || flush_i;
    assign empty_o = (num_to_translate == '0) && (num_to_exe == '0) && sb_empty_i;
    assign accept  = instr_valid_i && !full_o;

    assign tlb_vpn_o = ent_addr[xlat_ptr][31:12];

    // Translation and exception checks for the oldest untranslated entry
    always_comb begin
        xlat_vaddr = ent_addr[xlat_ptr];
        xlat_paddr = translate_en_i ? {tlb_ppn_i, xlat_vaddr[11:0]} : xlat_vaddr;
        xlat_ok    = (num_to_translate != '0) && (!translate_en_i || tlb_hit_i);
        xlat_cause = XC_NONE;
        if ((ent_size[xlat_ptr] == SIZE_HALF && xlat_vaddr[0]) ||
            (ent_size[xlat_ptr] == SIZE_WORD && xlat_vaddr[1:0] != 2'b00)) begin
            xlat_cause = ent_is_store[xlat_ptr] ? XC_ST_MISALIGNED : XC_LD_MISALIGNED;
        end else if (translate_en_i && ent_is_store[xlat_ptr] && !tlb_writable_i) begin
            xlat_cause = XC_ST_PAGE_FAULT;   // Read-only page
        end else if (xlat_paddr >= `PHYS_MEM_LIMIT) begin
            xlat_cause = ent_is_store[xlat_ptr] ? XC_ST_ACCESS_FAULT : XC_LD_ACCESS_FAULT;
        end
    end

    assign head_paddr_o     = ent_addr[head];
    assign head_size_o      = ent_size[head];
    assign head_data_o      = ent_data[head];
    assign head_gl_idx_o    = ent_gl_idx[head];
    assign issue_xcpt_o     = ent_xcpt[head];
    assign issue_is_store_o = ent_is_store[head];

    assign head_valid = (num_to_exe != '0) && !flush_i;

    // Head action: exception report, store push or load issue
    always_comb begin
        issue_o                = 1'b0;
        sb_push_o              = 1'b0;
        pmu_load_after_store_o = 1'b0;
        if (head_valid && ent_xcpt[head] != XC_NONE) begin
            issue_o = !port_busy_i;
        end else if (head_valid && ent_is_store[head]) begin
            sb_push_o = !sb_full_i;
        end else if (head_valid) begin
            issue_o                = !sb_collision_i && !port_busy_i;
            pmu_load_after_store_o = sb_collision_i;   // Held behind an older store
        end
    end

    assign pop = issue_o || sb_push_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head             <= '0;
            tail             <= '0;
            xlat_ptr         <= '0;
            num_to_translate <= '0;
            num_to_exe       <= '0;
        end else if (flush_i) begin
            head             <= '0;
            tail             <= '0;
            xlat_ptr         <= '0;
            num_to_translate <= '0;
            num_to_exe       <= '0;
        end else begin
            head             <= head + PTR_W'(pop);
            tail             <= tail + PTR_W'(accept);
            xlat_ptr         <= xlat_ptr + PTR_W'(xlat_ok);
            num_to_translate <= num_to_translate + CNT_W'(accept) - CNT_W'(xlat_ok);
            num_to_exe       <= num_to_exe + CNT_W'(xlat_ok) - CNT_W'(pop);
        end
    end

    // Tail and translate pointer never meet while the entry is untranslated
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ent_is_store[tail] <= instr_is_store_i;
            ent_size[tail]     <= instr_size_i;
            ent_addr[tail]     <= instr_addr_i;
            ent_data[tail]     <= instr_data_i;
            ent_gl_idx[tail]   <= instr_gl_idx_i;
        end
        if (xlat_ok) begin
            ent_addr[xlat_ptr] <= xlat_paddr;
            ent_xcpt[xlat_ptr] <= xlat_cause;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/store_buffer.sv ====
// Store buffer
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module store_buffer
    import lsq_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i,
    input  logic      push_i,
    input  paddr_t    push_paddr_i,
    input  mem_size_t push_size_i,
    input  word_t     push_data_i,
    input  gl_index_t push_gl_idx_i,
    input  logic      rob_store_ack_i,
    input  gl_index_t rob_store_gl_idx_i,
    input  paddr_t    load_paddr_i,
    output logic      full_o,
    output logic      empty_o,
    output logic      collision_o,
    output logic      drain_o,
    output paddr_t    drain_paddr_o,
    output mem_size_t drain_size_o,
    output word_t     drain_data_o,
    output gl_index_t drain_gl_idx_o
);

    localparam int PTR_W = $clog2(`SB_ENTRIES);

    logic      sb_valid  [`SB_ENTRIES];
    paddr_t    sb_paddr  [`SB_ENTRIES];
    mem_size_t sb_size   [`SB_ENTRIES];
    word_t     sb_data   [`SB_ENTRIES];
    gl_index_t sb_gl_idx [`SB_ENTRIES];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    assign full_o  = count == (PTR_W + 1)'(`SB_ENTRIES);
    assign empty_o = count == '0;

    // Oldest store leaves only on its own commit ack
    assign drain_o = !empty_o && !flush_i && rob_store_ack_i &&
                     (rob_store_gl_idx_i == sb_gl_idx[head]);

    assign drain_paddr_o  = sb_paddr[head];
    assign drain_size_o   = sb_size[head];
    assign drain_data_o   = sb_data[head];
    assign drain_gl_idx_o = sb_gl_idx[head];

    always_comb begin
        collision_o = 1'b0;
        for (int i = 0; i < `SB_ENTRIES; i++) begin
            if (sb_valid[i] && sb_paddr[i][31:2] == load_paddr_i[31:2]) collision_o = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `SB_ENTRIES; i++) begin
                sb_valid[i] <= 1'b0;
            end
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `SB_ENTRIES; i++) begin
                sb_valid[i] <= 1'b0;
            end
        end else begin
            if (push_i) sb_valid[tail] <= 1'b1;
            if (drain_o) sb_valid[head] <= 1'b0;
            head  <= head + PTR_W'(drain_o);
            tail  <= tail + PTR_W'(push_i);
            count <= count + (PTR_W + 1)'(push_i) - (PTR_W + 1)'(drain_o);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            sb_paddr[tail]  <= push_paddr_i;
            sb_size[tail]   <= push_size_i;
            sb_data[tail]   <= push_data_i;
            sb_gl_idx[tail] <= push_gl_idx_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
// Memory stage
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module mem_stage
    import lsq_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        drain_i,
    input  paddr_t      drain_paddr_i,
    input  mem_size_t   drain_size_i,
    input  word_t       drain_data_i,
    input  gl_index_t   drain_gl_idx_i,
    input  logic        issue_i,
    input  paddr_t      issue_paddr_i,
    input  mem_size_t   issue_size_i,
    input  gl_index_t   issue_gl_idx_i,
    input  logic        issue_is_store_i,
    input  xcpt_cause_t issue_xcpt_i,
    output logic        result_valid_o,
    output gl_index_t   result_gl_idx_o,
    output logic        result_is_store_o,
    output word_t       result_data_o,
    output xcpt_cause_t result_xcpt_o
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    word_t mem [`MEM_WORDS];

    logic [3:0] byte_en;
    word_t      wr_word;
    word_t      rd_word;
    word_t      ld_data;

    // Store data sits in the low bytes, shift it into its lanes
    always_comb begin
        wr_word = drain_data_i << {drain_paddr_i[1:0], 3'b000};
        case (drain_size_i)
            SIZE_BYTE: byte_en = 4'b0001 << drain_paddr_i[1:0];
            SIZE_HALF: byte_en = 4'b0011 << drain_paddr_i[1:0];
            default:   byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        rd_word = mem[issue_paddr_i[IDX_W+1:2]] >> {issue_paddr_i[1:0], 3'b000};
        case (issue_size_i)
            SIZE_BYTE: ld_data = {24'b0, rd_word[7:0]};
            SIZE_HALF: ld_data = {16'b0, rd_word[15:0]};
            default:   ld_data = rd_word;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (drain_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[drain_paddr_i[IDX_W+1:2]][8*b +: 8] <= wr_word[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) result_valid_o <= 1'b0;
        else         result_valid_o <= drain_i || issue_i;
    end

    // Drain owns the port, the queue holds its issue meanwhile
    always_ff @(posedge clk_i) begin
        if (drain_i) begin
            result_gl_idx_o   <= drain_gl_idx_i;
            result_is_store_o <= 1'b1;
            result_data_o     <= '0;
            result_xcpt_o     <= XC_NONE;
        end else if (issue_i) begin
            result_gl_idx_o   <= issue_gl_idx_i;
            result_is_store_o <= issue_is_store_i;
            result_data_o     <= (issue_xcpt_i == XC_NONE) ? ld_data : '0;
            result_xcpt_o     <= issue_xcpt_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsq_subsystem.sv ====
// Load/store subsystem top
`timescale 1ns/1ps
`default_nettype none

module lsq_subsystem
    import lsq_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  logic        instr_valid_i,
    input  logic        instr_is_store_i,
    input  mem_size_t   instr_size_i,
    input  vaddr_t      instr_addr_i,
    input  word_t       instr_data_i,
    input  gl_index_t   instr_gl_idx_i,
    input  logic        translate_en_i,
    input  logic        tlb_fill_i,
    input  vpn_t        tlb_fill_vpn_i,
    input  ppn_t        tlb_fill_ppn_i,
    input  logic        tlb_fill_writable_i,
    input  logic        rob_store_ack_i,
    input  gl_index_t   rob_store_gl_idx_i,
    output logic        full_o,
    output logic        empty_o,
    output logic        pmu_load_after_store_o,
    output logic        result_valid_o,
    output gl_index_t   result_gl_idx_o,
    output logic        result_is_store_o,
    output word_t       result_data_o,
    output xcpt_cause_t result_xcpt_o
);

    vpn_t        lookup_vpn;
    logic        lookup_hit;
    ppn_t        lookup_ppn;
    logic        lookup_writable;
    logic        sb_full;
    logic        sb_empty;
    logic        sb_collision;
    logic        sb_push;
    logic        drain;         // Also the port-busy signal
    paddr_t      head_paddr;
    mem_size_t   head_size;
    word_t       head_data;
    gl_index_t   head_gl_idx;
    logic        issue;
    xcpt_cause_t issue_xcpt;
    logic        issue_is_store;
    paddr_t      drain_paddr;
    mem_size_t   drain_size;
    word_t       drain_data;
    gl_index_t   drain_gl_idx;

    dtlb i_dtlb (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .fill_i            (tlb_fill_i),
        .fill_vpn_i        (tlb_fill_vpn_i),
        .fill_ppn_i        (tlb_fill_ppn_i),
        .fill_writable_i   (tlb_fill_writable_i),
        .lookup_vpn_i      (lookup_vpn),
        .lookup_hit_o      (lookup_hit),
        .lookup_ppn_o      (lookup_ppn),
        .lookup_writable_o (lookup_writable)
    );

    load_store_queue i_load_store_queue (
        .clk_i                  (clk_i),
        .rstn_i                 (rstn_i),
        .flush_i                (flush_i),
        .instr_valid_i          (instr_valid_i),
        .instr_is_store_i       (instr_is_store_i),
        .instr_size_i           (instr_size_i),
        .instr_addr_i           (instr_addr_i),
        .instr_data_i           (instr_data_i),
        .instr_gl_idx_i         (instr_gl_idx_i),
        .translate_en_i         (translate_en_i),
        .tlb_hit_i              (lookup_hit),
        .tlb_ppn_i              (lookup_ppn),
        .tlb_writable_i         (lookup_writable),
        .sb_full_i              (sb_full),
        .sb_empty_i             (sb_empty),
        .sb_collision_i         (sb_collision),
        .port_busy_i            (drain),
        .full_o                 (full_o),
        .empty_o                (empty_o),
        .pmu_load_after_store_o (pmu_load_after_store_o),
        .tlb_vpn_o              (lookup_vpn),
        .sb_push_o              (sb_push),
        .head_paddr_o           (head_paddr),
        .head_size_o            (head_size),
        .head_data_o            (head_data),
        .head_gl_idx_o          (head_gl_idx),
        .issue_o                (issue),
        .issue_xcpt_o           (issue_xcpt),
        .issue_is_store_o       (issue_is_store)
    );

    store_buffer i_store_buffer (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .flush_i            (flush_i),
        .push_i             (sb_push),
        .push_paddr_i       (head_paddr),
        .push_size_i        (head_size),
        .push_data_i        (head_data),
        .push_gl_idx_i      (head_gl_idx),
        .rob_store_ack_i    (rob_store_ack_i),
        .rob_store_gl_idx_i (rob_store_gl_idx_i),
        .load_paddr_i       (head_paddr),
        .full_o             (sb_full),
        .empty_o            (sb_empty),
        .collision_o        (sb_collision),
        .drain_o            (drain),
        .drain_paddr_o      (drain_paddr),
        .drain_size_o       (drain_size),
        .drain_data_o       (drain_data),
        .drain_gl_idx_o     (drain_gl_idx)
    );

    mem_stage i_mem_stage (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .drain_i           (drain),
        .drain_paddr_i     (drain_paddr),
        .drain_size_i      (drain_size),
        .drain_data_i      (drain_data),
        .drain_gl_idx_i    (drain_gl_idx),
        .issue_i           (issue),
        .issue_paddr_i     (head_paddr),
        .issue_size_i      (head_size),
        .issue_gl_idx_i    (head_gl_idx),
        .issue_is_store_i  (issue_is_store),
        .issue_xcpt_i      (issue_xcpt),
        .result_valid_o    (result_valid_o),
        .result_gl_idx_o   (result_gl_idx_o),
        .result_is_store_o (result_is_store_o),
        .result_data_o     (result_data_o),
        .result_xcpt_o     (result_xcpt_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_lsq_subsystem.sv ====
// Load/store subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module tb_lsq_subsystem
    import lsq_pkg::*;
();

    logic        clk_i;
    logic        rstn_i;
    logic        flush_i;
    logic        instr_valid_i;
    logic        instr_is_store_i;
    mem_size_t   instr_size_i;
    vaddr_t      instr_addr_i;
    word_t       instr_data_i;
    gl_index_t   instr_gl_idx_i;
    logic        translate_en_i;
    logic        tlb_fill_i;
    vpn_t        tlb_fill_vpn_i;
    ppn_t        tlb_fill_ppn_i;
    logic        tlb_fill_writable_i;
    logic        rob_store_ack_i;
    gl_index_t   rob_store_gl_idx_i;
    logic        full_o;
    logic        empty_o;
    logic        pmu_load_after_store_o;
    logic        result_valid_o;
    gl_index_t   result_gl_idx_o;
    logic        result_is_store_o;
    word_t       result_data_o;
    xcpt_cause_t result_xcpt_o;

    // Reference model state
    logic [31:0] ref_mem [256];
    gl_index_t   exp_gl   [$];
    logic        exp_st   [$];
    logic [31:0] exp_data [$];
    logic [2:0]  exp_xc   [$];
    logic        store_done [64];

    int          errors;
    int          checks;
    int          n_issued;
    int          cycles;
    int          seed;
    gl_index_t   gl_next;
    gl_index_t   st_idx;
    gl_index_t   ld_idx;
    int          k;
    int          sent;
    logic        seen;
    logic [31:0] r;
    logic [31:0] wdata;
    logic [1:0]  sz_bits;
    logic [1:0]  lane;
    logic [11:0] offs;
    logic [19:0] ppn;
    logic [19:0] vpn;
    mem_size_t   sz;

    lsq_subsystem i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] fill_pattern(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    // Value a load returns, zero-extended by size
    function automatic logic [31:0] ref_load(input logic [31:0] pa, input mem_size_t s);
        logic [31:0] v;
        v = ref_mem[pa[9:2]] >> (8 * pa[1:0]);
        if (s == SIZE_BYTE) v = v & 32'h0000_00FF;
        else if (s == SIZE_HALF) v = v & 32'h0000_FFFF;
        return v;
    endfunction

    task automatic ref_store(input logic [31:0] pa, input mem_size_t s, input logic [31:0] d);
        int n;
        int ln;
        n = (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            ln = pa[1:0] + b;
            ref_mem[pa[9:2]][8*ln +: 8] = d[8*b +: 8];
        end
    endtask

    task automatic push_expect(input gl_index_t idx, input logic st, input logic [31:0] d,
                               input logic [2:0] xc);
        exp_gl.push_back(idx);
        exp_st.push_back(st);
        exp_data.push_back(d);
        exp_xc.push_back(xc);
    endtask

    // Called at a falling edge, returns at a falling edge
    task automatic send(input logic st, input mem_size_t s, input logic [31:0] addr,
                        input logic [31:0] d, output gl_index_t idx);
        while (full_o) @(negedge clk_i);
        idx              = gl_next;
        instr_valid_i    = 1'b1;
        instr_is_store_i = st;
        instr_size_i     = s;
        instr_addr_i     = addr;
        instr_data_i     = d;
        instr_gl_idx_i   = idx;
        gl_next          = gl_next + 1'b1;
        n_issued++;
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic note_commit(input gl_index_t idx, input logic [31:0] pa, input mem_size_t s,
                               input logic [31:0] d);
        push_expect(idx, 1'b1, 32'h0, XC_NONE);   // Store completes with data 0
        ref_store(pa, s, d);
    endtask

    // Hold the commit ack until the store's result shows up
    task automatic ack_wait(input gl_index_t idx);
        store_done[idx]    = 1'b0;
        rob_store_ack_i    = 1'b1;
        rob_store_gl_idx_i = idx;
        while (!store_done[idx]) @(negedge clk_i);
        rob_store_ack_i = 1'b0;
    endtask

    task automatic store_commit(input mem_size_t s, input logic [31:0] va,
                                input logic [31:0] pa, input logic [31:0] d);
        gl_index_t idx;
        send(1'b1, s, va, d, idx);
        note_commit(idx, pa, s, d);
        ack_wait(idx);
    endtask

    task automatic load_check(input mem_size_t s, input logic [31:0] va, input logic [31:0] pa);
        gl_index_t idx;
        push_expect(gl_next, 1'b0, ref_load(pa, s), XC_NONE);
        send(1'b0, s, va, 32'h0, idx);
    endtask

    task automatic xcpt_check(input logic st, input mem_size_t s, input logic [31:0] va,
                              input xcpt_cause_t xc);
        gl_index_t idx;
        push_expect(gl_next, st, 32'h0, xc);
        send(st, s, va, 32'h1234_5678, idx);
    endtask

    task automatic tlb_fill(input logic [19:0] v, input logic [19:0] p, input logic wr);
        tlb_fill_i          = 1'b1;
        tlb_fill_vpn_i      = v;
        tlb_fill_ppn_i      = p;
        tlb_fill_writable_i = wr;
        @(negedge clk_i);
        tlb_fill_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_gl.size() != 0) @(negedge clk_i);
    endtask

    // Result checker against the expected queue
    always @(posedge clk_i) begin
        if (rstn_i && result_valid_o) begin
            if (exp_gl.size() == 0) begin
                errors++;
                $display("Fail %0t: unexpected result for gl_idx %0d", $time, result_gl_idx_o);
            end else begin
                checks++;
                assert (result_gl_idx_o == exp_gl[0] && result_is_store_o == exp_st[0] &&
                        result_data_o == exp_data[0] && result_xcpt_o == exp_xc[0])
                else begin
                    errors++;
                    $display("Fail %0t: got idx %0d st %0b data %h xc %0d, expected %0d %0b %h %0d",
                             $time, result_gl_idx_o, result_is_store_o, result_data_o,
                             result_xcpt_o, exp_gl[0], exp_st[0], exp_data[0], exp_xc[0]);
                end
                void'(exp_gl.pop_front());
                void'(exp_st.pop_front());
                void'(exp_data.pop_front());
                void'(exp_xc.pop_front());
            end
            if (result_is_store_o) store_done[result_gl_idx_o] = 1'b1;
        end
    end

    // Run limit grows with the number of issued instructions
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 40 * n_issued + 200) begin
            $display("Timeout after %0d cycles, %0d results still missing", cycles, exp_gl.size());
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        errors = 0;
        checks = 0;
        n_issued = 0;
        cycles = 0;
        seed = 53930;
        gl_next = '0;
        rstn_i = 1'b0;
        flush_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_is_store_i = 1'b0;
        instr_size_i = SIZE_WORD;
        instr_addr_i = '0;
        instr_data_i = '0;
        instr_gl_idx_i = '0;
        translate_en_i = 1'b0;
        tlb_fill_i = 1'b0;
        tlb_fill_vpn_i = '0;
        tlb_fill_ppn_i = '0;
        tlb_fill_writable_i = 1'b0;
        rob_store_ack_i = 1'b0;
        rob_store_gl_idx_i = '0;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;
        assert (!result_valid_o && !pmu_load_after_store_o && empty_o)
        else begin
            errors++;
            $display("Fail %0t: outputs not idle after reset", $time);
        end

        // Store then load with translation off
        for (k = 0; k < 64; k++) store_commit(SIZE_WORD, 4 * k, 4 * k, fill_pattern(4 * k));
        store_commit(SIZE_BYTE, 32'h11, 32'h11, 32'h0000_005A);
        store_commit(SIZE_HALF, 32'h22, 32'h22, 32'h0000_BEEF);
        store_commit(SIZE_WORD, 32'h30, 32'h30, 32'hCAFE_F00D);
        store_commit(SIZE_BYTE, 32'h03, 32'h03, 32'hFFFF_FF81);
        load_check(SIZE_BYTE, 32'h11, 32'h11);
        load_check(SIZE_HALF, 32'h10, 32'h10);
        load_check(SIZE_WORD, 32'h10, 32'h10);
        load_check(SIZE_HALF, 32'h22, 32'h22);
        load_check(SIZE_BYTE, 32'h23, 32'h23);
        load_check(SIZE_WORD, 32'h30, 32'h30);
        load_check(SIZE_BYTE, 32'h03, 32'h03);
        load_check(SIZE_HALF, 32'h02, 32'h02);
        load_check(SIZE_WORD, 32'h20, 32'h20);
        wait_idle();

        // Translation waits for a fill
        translate_en_i = 1'b1;
        send(1'b0, SIZE_WORD, 32'h0000_5024, 32'h0, ld_idx);
        repeat (20) @(negedge clk_i);
        push_expect(ld_idx, 1'b0, ref_load(32'h0000_3024, SIZE_WORD), XC_NONE);
        tlb_fill(20'h00005, 20'h00003, 1'b1);
        wait_idle();

        // Exceptions, checked in priority order
        tlb_fill(20'h00006, 20'h00004, 1'b0);   // Read-only page
        tlb_fill(20'h00007, 20'h00010, 1'b1);   // Beyond physical memory
        xcpt_check(1'b0, SIZE_HALF, 32'h0000_5011, XC_LD_MISALIGNED);
        xcpt_check(1'b1, SIZE_WORD, 32'h0000_5042, XC_ST_MISALIGNED);
        xcpt_check(1'b0, SIZE_WORD, 32'h0000_5046, XC_LD_MISALIGNED);
        xcpt_check(1'b1, SIZE_BYTE, 32'h0000_6040, XC_ST_PAGE_FAULT);
        xcpt_check(1'b1, SIZE_HALF, 32'h0000_6041, XC_ST_MISALIGNED);
        load_check(SIZE_WORD, 32'h0000_6040, 32'h0000_4040);
        xcpt_check(1'b0, SIZE_WORD, 32'h0000_7044, XC_LD_ACCESS_FAULT);
        xcpt_check(1'b1, SIZE_HALF, 32'h0000_7046, XC_ST_ACCESS_FAULT);
        load_check(SIZE_WORD, 32'h0000_5040, 32'h0000_3040);
        load_check(SIZE_WORD, 32'h0000_5044, 32'h0000_3044);
        wait_idle();
        translate_en_i = 1'b0;

        // Load behind an uncommitted store to the same word
        send(1'b1, SIZE_WORD, 32'h48, 32'hC0FF_EE11, st_idx);
        send(1'b0, SIZE_WORD, 32'h48, 32'h0, ld_idx);
        seen = 1'b0;
        for (k = 0; k < 20 && !seen; k++) begin
            @(negedge clk_i);
            seen = pmu_load_after_store_o;
        end
        assert (seen) else begin
            errors++;
            $display("Fail %0t: no load-after-store pulse", $time);
        end
        repeat (5) @(negedge clk_i);
        note_commit(st_idx, 32'h48, SIZE_WORD, 32'hC0FF_EE11);
        push_expect(ld_idx, 1'b0, ref_load(32'h48, SIZE_WORD), XC_NONE);
        ack_wait(st_idx);
        wait_idle();

        // Back-pressure without commits, then flush
        sent = 0;
        while (!full_o && sent < 20) begin
            send(1'b1, SIZE_WORD, 32'h80 + 4 * sent, 32'hDEAD_0000 + sent, st_idx);
            sent++;
        end
        assert (full_o && sent == `LSQ_ENTRIES + `SB_ENTRIES) else begin
            errors++;
            $display("Fail %0t: full after %0d stores", $time, sent);
        end
        flush_i = 1'b1;
        @(negedge clk_i);
        // Queue already cleared here, so only the flush can hold full_o high
        assert (full_o) else begin
            errors++;
            $display("Fail %0t: full_o low during flush", $time);
        end
        flush_i = 1'b0;
        assert (empty_o) else begin
            errors++;
            $display("Fail %0t: empty_o low after flush", $time);
        end
        repeat (10) @(negedge clk_i);
        for (k = 0; k < 12; k++) load_check(SIZE_WORD, 32'h80 + 4 * k, 32'h80 + 4 * k);
        wait_idle();

        // Random mix over two mapped pages
        translate_en_i = 1'b1;
        tlb_fill(20'h00008, 20'h00000, 1'b1);
        for (k = 0; k < 40; k++) begin
            r       = $random(seed);
            wdata   = $random(seed);
            vpn     = r[0] ? 20'h00005 : 20'h00008;
            ppn     = r[0] ? 20'h00003 : 20'h00000;
            sz_bits = (r[9:8] == 2'b11) ? 2'b10 : r[9:8];
            sz      = mem_size_t'(sz_bits);
            lane    = (sz == SIZE_BYTE) ? r[11:10] : (sz == SIZE_HALF) ? {r[11], 1'b0} : 2'b00;
            offs    = {4'b0000, r[7:2], lane};
            if (r[12]) store_commit(sz, {vpn, offs}, {ppn, offs}, wdata);
            else load_check(sz, {vpn, offs}, {ppn, offs});
        end
        wait_idle();
        assert (empty_o) else begin
            errors++;
            $display("Fail %0t: empty_o low at the end", $time);
        end

        repeat (5) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/lsq_pkg.sv
verilog/dtlb.sv
verilog/load_store_queue.sv
verilog/store_buffer.sv
verilog/mem_stage.sv
verilog/lsq_subsystem.sv
verification/tb_lsq_subsystem.sv
